/* verilog/router_pkg.sv */
// ----------------------------------------------------------------------
// Router package: flit layout, port numbering and shared vector types
// for the five-port mesh router
// ----------------------------------------------------------------------
package router_pkg;

  // ----------------------------------------------------------------------
  // Sizes
  // ----------------------------------------------------------------------
  localparam int FLIT_W    = 64;
  localparam int HOP_W     = 4;
  localparam int NUM_PORTS = 5;

  // Port numbering, also the bit order of every port vector
  localparam int PORT_UP    = 0;
  localparam int PORT_DOWN  = 1;
  localparam int PORT_LEFT  = 2;
  localparam int PORT_RIGHT = 3;
  localparam int PORT_NIC   = 4;

  // ----------------------------------------------------------------------
  // Flit fields
  // ----------------------------------------------------------------------
  // Virtual channel, matched against the router polarity slot
  localparam int VC_BIT   = 63;

  // X direction, 0 is right and 1 is left
  localparam int XDIR_BIT = 62;

  // Y direction, 0 is up and 1 is down
  localparam int YDIR_BIT = 61;

  // Remaining X hops
  localparam int HOPX_MSB = 55;
  localparam int HOPX_LSB = 52;

  // Remaining Y hops
  localparam int HOPY_MSB = 51;
  localparam int HOPY_LSB = 48;

  // Bits 47:0 carry payload and pass through untouched

  // ----------------------------------------------------------------------
  // Types
  // ----------------------------------------------------------------------
  typedef logic [FLIT_W-1:0] flit_t;

  typedef logic [HOP_W-1:0] hop_t;

  // One bit per port: requests, readies, grants
  typedef logic [NUM_PORTS-1:0] port_vec_t;

  // Port number, wide enough for 0..NUM_PORTS-1
  typedef logic [2:0] port_idx_t;

endpackage

/* verilog/flit_buffer.sv */
// ----------------------------------------------------------------------
// Flit buffer: one-entry elastic register with valid/ready on both sides
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module flit_buffer (
  input  logic              clk,
  input  logic              reset,
  // Upstream side
  input  logic              in_valid,
  input  router_pkg::flit_t in_flit,
  output logic              in_ready,
  // Downstream side
  output logic              out_valid,
  output router_pkg::flit_t out_flit,
  input  logic              out_ready
);
  import router_pkg::*;

  logic  full;
  flit_t data_q;
  logic  pop;
  logic  push;

  // Entry leaves when held and taken downstream
  assign pop = full & out_ready;

  // Room when empty, or when the current entry leaves this cycle
  assign in_ready = ~full | pop;

  assign push = in_valid & in_ready;

  // ----------------------------------------------------------------------
  // Occupancy
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      full <= 1'b0;
    end else if (push) begin
      // Push alone or push with pop, stays full either way
      full <= 1'b1;
    end else if (pop) begin
      full <= 1'b0;
    end
  end

  // Payload register, overwritten on every push
  always_ff @(posedge clk) begin
    if (push) begin
      data_q <= in_flit;
    end
  end

  assign out_valid = full;
  assign out_flit  = data_q;

endmodule

/* verilog/input_port.sv */
// ----------------------------------------------------------------------
// Input port: buffers one arriving flit and picks its output by XY
// routing, decrementing the hop count used on this hop
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module input_port (
  input  logic                  clk,
  input  logic                  reset,
  // Link side
  input  logic                  in_valid,
  input  router_pkg::flit_t     in_flit,
  output logic                  in_ready,
  // Crossbar side
  output router_pkg::port_vec_t request,
  output router_pkg::flit_t     next_flit,
  input  router_pkg::port_vec_t out_ready
);
  import router_pkg::*;

  logic  buf_valid;
  flit_t buf_flit;
  logic  pop;
  hop_t  hop_x;
  hop_t  hop_y;

  // ----------------------------------------------------------------------
  // Input buffer
  // ----------------------------------------------------------------------
  flit_buffer in_buf_inst (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_flit   (in_flit),
    .in_ready  (in_ready),
    .out_valid (buf_valid),
    .out_flit  (buf_flit),
    .out_ready (pop)
  );

  assign hop_x = buf_flit[HOPX_MSB:HOPX_LSB];
  assign hop_y = buf_flit[HOPY_MSB:HOPY_LSB];

  // ----------------------------------------------------------------------
  // Route choice, X first, then Y, then local delivery
  // ----------------------------------------------------------------------
  always_comb begin
    request   = '0;
    next_flit = buf_flit;
    if (hop_x != '0) begin
      // XDIR 0 goes right, 1 goes left
      if (buf_flit[XDIR_BIT]) begin
        request[PORT_LEFT] = buf_valid;
      end else begin
        request[PORT_RIGHT] = buf_valid;
      end
      next_flit[HOPX_MSB:HOPX_LSB] = hop_x - hop_t'(1);
    end else if (hop_y != '0) begin
      // YDIR 0 goes up, 1 goes down
      if (buf_flit[YDIR_BIT]) begin
        request[PORT_DOWN] = buf_valid;
      end else begin
        request[PORT_UP] = buf_valid;
      end
      next_flit[HOPY_MSB:HOPY_LSB] = hop_y - hop_t'(1);
    end else begin
      // Arrived, flit goes to the NIC as it is
      request[PORT_NIC] = buf_valid;
    end
  end

  // Pop only when the chosen output takes the flit
  assign pop = |(request & out_ready);

endmodule

/* verilog/rr_arbiter.sv */
// ----------------------------------------------------------------------
// Round-robin arbiter for five requesters, pointer moves only on advance
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module rr_arbiter (
  input  logic                  clk,
  input  logic                  reset,
  input  router_pkg::port_vec_t request,
  input  logic                  advance,
  output router_pkg::port_vec_t grant
);
  import router_pkg::*;

  // Highest-priority index for the next grant
  port_idx_t ptr;
  port_idx_t grant_idx;

  // ----------------------------------------------------------------------
  // One-hot grant, first requester at or after ptr, wrapping around
  // ----------------------------------------------------------------------
  always_comb begin
    int   idx;
    logic found;
    grant     = '0;
    grant_idx = ptr;
    found     = 1'b0;
    for (int off = 0; off < NUM_PORTS; off++) begin
      idx = int'(ptr) + off;
      // Wrap back into 0..NUM_PORTS-1
      if (idx >= NUM_PORTS) begin
        idx = idx - NUM_PORTS;
      end
      if (!found && request[idx]) begin
        grant[idx] = 1'b1;
        grant_idx  = port_idx_t'(idx);
        found      = 1'b1;
      end
    end
  end

  // Pointer goes one past the winner, only when its flit was taken
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ptr <= '0;
    end else if (advance) begin
      if (grant_idx == port_idx_t'(NUM_PORTS - 1)) begin
        ptr <= '0;
      end else begin
        ptr <= grant_idx + port_idx_t'(1);
      end
    end
  end

endmodule

/* verilog/output_port.sv */
// ----------------------------------------------------------------------
// Output port: arbitrates among inputs, admits a flit only in its VC
// slot and holds it in a one-entry buffer toward the link
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module output_port (
  input  logic                                            clk,
  input  logic                                            reset,
  input  logic                                            polarity,
  // Crossbar side, indexed by input port
  input  router_pkg::port_vec_t                           request,
  input  router_pkg::flit_t [router_pkg::NUM_PORTS-1:0]   in_flits,
  output router_pkg::port_vec_t                           grant_ready,
  // Link side
  output logic                                            out_valid,
  output router_pkg::flit_t                               out_flit,
  input  logic                                            out_ready
);
  import router_pkg::*;

  port_vec_t grant;
  flit_t     sel_flit;
  logic      vc_match;
  logic      buf_ready;
  logic      push;

  // ----------------------------------------------------------------------
  // Arbitration
  // ----------------------------------------------------------------------
  rr_arbiter arb_inst (
    .clk     (clk),
    .reset   (reset),
    .request (request),
    .advance (push),
    .grant   (grant)
  );

  // Mux the granted flit, zero when nobody is granted
  always_comb begin
    sel_flit = '0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      if (grant[i]) begin
        sel_flit = in_flits[i];
      end
    end
  end

  // Flit may enter only in the slot matching its VC
  assign vc_match = (sel_flit[VC_BIT] == polarity);

  // Grant, VC slot and buffer room all needed for a push
  assign push = (|grant) & vc_match & buf_ready;

  // Ready back only to the winner, and only when its flit goes in
  assign grant_ready = push ? grant : '0;

  // ----------------------------------------------------------------------
  // Output buffer
  // ----------------------------------------------------------------------
  flit_buffer out_buf_inst (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (push),
    .in_flit   (sel_flit),
    .in_ready  (buf_ready),
    .out_valid (out_valid),
    .out_flit  (out_flit),
    .out_ready (out_ready)
  );

endmodule

/* verilog/mesh_router.sv */
// ----------------------------------------------------------------------
// Mesh router: five input and five output ports joined by a 5x5
// crossbar, with a polarity slot that toggles every cycle
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module mesh_router (
  input  logic              clk,
  input  logic              reset,
  // Up link
  input  logic              up_in_valid,
  input  router_pkg::flit_t up_in_flit,
  output logic              up_in_ready,
  output logic              up_out_valid,
  output router_pkg::flit_t up_out_flit,
  input  logic              up_out_ready,
  // Down link
  input  logic              down_in_valid,
  input  router_pkg::flit_t down_in_flit,
  output logic              down_in_ready,
  output logic              down_out_valid,
  output router_pkg::flit_t down_out_flit,
  input  logic              down_out_ready,
  // Left link
  input  logic              left_in_valid,
  input  router_pkg::flit_t left_in_flit,
  output logic              left_in_ready,
  output logic              left_out_valid,
  output router_pkg::flit_t left_out_flit,
  input  logic              left_out_ready,
  // Right link
  input  logic              right_in_valid,
  input  router_pkg::flit_t right_in_flit,
  output logic              right_in_ready,
  output logic              right_out_valid,
  output router_pkg::flit_t right_out_flit,
  input  logic              right_out_ready,
  // Local NIC
  input  logic              nic_in_valid,
  input  router_pkg::flit_t nic_in_flit,
  output logic              nic_in_ready,
  output logic              nic_out_valid,
  output router_pkg::flit_t nic_out_flit,
  input  logic              nic_out_ready,
  output logic              polarity_to_nic
);
  import router_pkg::*;

  logic polarity;

  // Link signals gathered by port number
  port_vec_t                 in_valid;
  flit_t [NUM_PORTS-1:0]     in_flit;
  port_vec_t                 in_ready;
  port_vec_t                 out_valid;
  flit_t [NUM_PORTS-1:0]     out_flit;
  port_vec_t                 out_ready;

  // Crossbar: in_request[i][o] from input i, out_request[o][i] into output o
  port_vec_t [NUM_PORTS-1:0] in_request;
  port_vec_t [NUM_PORTS-1:0] out_request;
  flit_t [NUM_PORTS-1:0]     next_flit;
  // grant_ready[o][i] from output o, in_readies[i][o] back to input i
  port_vec_t [NUM_PORTS-1:0] grant_ready;
  port_vec_t [NUM_PORTS-1:0] in_readies;

  // ----------------------------------------------------------------------
  // Polarity slot, 0 after reset then flips every cycle
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      polarity <= 1'b0;
    end else begin
      polarity <= ~polarity;
    end
  end

  assign polarity_to_nic = polarity;

  // ----------------------------------------------------------------------
  // Named links to port-number arrays
  // ----------------------------------------------------------------------
  assign in_valid  = {nic_in_valid, right_in_valid, left_in_valid,
                      down_in_valid, up_in_valid};
  assign in_flit   = {nic_in_flit, right_in_flit, left_in_flit,
                      down_in_flit, up_in_flit};
  assign out_ready = {nic_out_ready, right_out_ready, left_out_ready,
                      down_out_ready, up_out_ready};

  assign {nic_in_ready, right_in_ready, left_in_ready,
          down_in_ready, up_in_ready} = in_ready;
  assign {nic_out_valid, right_out_valid, left_out_valid,
          down_out_valid, up_out_valid} = out_valid;
  assign {nic_out_flit, right_out_flit, left_out_flit,
          down_out_flit, up_out_flit} = out_flit;

  // ----------------------------------------------------------------------
  // Crossbar transpose, own slot masked since U-turns are not routed
  // ----------------------------------------------------------------------
  for (genvar i = 0; i < NUM_PORTS; i++) begin : g_xbar_row
    for (genvar o = 0; o < NUM_PORTS; o++) begin : g_xbar_col
      assign out_request[o][i] = (i == o) ? 1'b0 : in_request[i][o];
      assign in_readies[i][o]  = grant_ready[o][i];
    end
  end

  // ----------------------------------------------------------------------
  // Port instances
  // ----------------------------------------------------------------------
  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
    input_port input_port_inst (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (in_valid[p]),
      .in_flit   (in_flit[p]),
      .in_ready  (in_ready[p]),
      .request   (in_request[p]),
      .next_flit (next_flit[p]),
      .out_ready (in_readies[p])
    );

    output_port output_port_inst (
      .clk         (clk),
      .reset       (reset),
      .polarity    (polarity),
      .request     (out_request[p]),
      .in_flits    (next_flit),
      .grant_ready (grant_ready[p]),
      .out_valid   (out_valid[p]),
      .out_flit    (out_flit[p]),
      .out_ready   (out_ready[p])
    );
  end

endmodule

/* dv/router_tb_table.svh */
// ----------------------------------------------------------------------
// Router test table: one flit per row with its exit port and exit hop
// counts, plus the flit builder used by stimulus and checking
// ----------------------------------------------------------------------

// Tag is pass * TAG_STRIDE + row, carried in payload bits 15:0
localparam int NUM_ROWS   = 18;
localparam int TAG_STRIDE = 64;

typedef struct packed {
  port_idx_t src;
  logic      vc;
  logic      xdir;
  logic      ydir;
  hop_t      hop_x;
  hop_t      hop_y;
  port_idx_t dst;
  hop_t      exp_hop_x;
  hop_t      exp_hop_y;
} table_row_t;

function automatic table_row_t table_row(int i);
  // Columns: src, vc, xdir, ydir, hop x, hop y, exit port, exit hop x, exit hop y
  // Ports: 0 up, 1 down, 2 left, 3 right, 4 nic
  case (i)
    0:  table_row = '{3'd4, 1'b0, 1'b0, 1'b0, 4'd3,  4'd2,  3'd3, 4'd2,  4'd2};
    1:  table_row = '{3'd4, 1'b1, 1'b1, 1'b0, 4'd1,  4'd0,  3'd2, 4'd0,  4'd0};
    2:  table_row = '{3'd4, 1'b0, 1'b0, 1'b1, 4'd0,  4'd5,  3'd1, 4'd0,  4'd4};
    3:  table_row = '{3'd4, 1'b1, 1'b1, 1'b0, 4'd0,  4'd1,  3'd0, 4'd0,  4'd0};
    // Four links into the NIC at once, twice over
    4:  table_row = '{3'd0, 1'b0, 1'b0, 1'b0, 4'd0,  4'd0,  3'd4, 4'd0,  4'd0};
    5:  table_row = '{3'd1, 1'b1, 1'b1, 1'b1, 4'd0,  4'd0,  3'd4, 4'd0,  4'd0};
    6:  table_row = '{3'd2, 1'b0, 1'b1, 1'b0, 4'd0,  4'd0,  3'd4, 4'd0,  4'd0};
    7:  table_row = '{3'd3, 1'b1, 1'b0, 1'b1, 4'd0,  4'd0,  3'd4, 4'd0,  4'd0};
    8:  table_row = '{3'd0, 1'b1, 1'b0, 1'b0, 4'd0,  4'd0,  3'd4, 4'd0,  4'd0};
    9:  table_row = '{3'd1, 1'b0, 1'b0, 1'b0, 4'd0,  4'd0,  3'd4, 4'd0,  4'd0};
    10: table_row = '{3'd2, 1'b1, 1'b0, 1'b0, 4'd0,  4'd0,  3'd4, 4'd0,  4'd0};
    11: table_row = '{3'd3, 1'b0, 1'b0, 1'b0, 4'd0,  4'd0,  3'd4, 4'd0,  4'd0};
    // Through traffic between links
    12: table_row = '{3'd2, 1'b0, 1'b0, 1'b0, 4'd2,  4'd1,  3'd3, 4'd1,  4'd1};
    13: table_row = '{3'd3, 1'b1, 1'b1, 1'b1, 4'd4,  4'd0,  3'd2, 4'd3,  4'd0};
    14: table_row = '{3'd0, 1'b1, 1'b0, 1'b1, 4'd0,  4'd3,  3'd1, 4'd0,  4'd2};
    15: table_row = '{3'd1, 1'b0, 1'b1, 1'b0, 4'd0,  4'd15, 3'd0, 4'd0,  4'd14};
    16: table_row = '{3'd0, 1'b0, 1'b1, 1'b0, 4'd15, 4'd7,  3'd2, 4'd14, 4'd7};
    17: table_row = '{3'd1, 1'b1, 1'b0, 1'b1, 4'd0,  4'd0,  3'd4, 4'd0,  4'd0};
    default: table_row = '0;
  endcase
endfunction

// Flit as sent, or as expected at the exit when at_exit is set
function automatic flit_t build_flit(table_row_t r, int tag, logic at_exit);
  flit_t f;
  f = '0;
  f[VC_BIT]   = r.vc;
  f[XDIR_BIT] = r.xdir;
  f[YDIR_BIT] = r.ydir;
  // Filler in the spare header bits, must pass through untouched
  f[60:56] = 5'(tag * 7 + 3);
  f[HOPX_MSB:HOPX_LSB] = at_exit ? r.exp_hop_x : r.hop_x;
  f[HOPY_MSB:HOPY_LSB] = at_exit ? r.exp_hop_y : r.hop_y;
  f[47:16] = {16'(tag) ^ 16'hc0de, 16'(tag * 13)};
  f[15:0]  = 16'(tag);
  build_flit = f;
endfunction

/* dv/router_checker.sv */
// ----------------------------------------------------------------------
// Router checker: watches the links and checks exit port, flit value,
// VC slot, ordering and output stability, counting every error
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module router_checker (
  input  logic                                          clk,
  input  logic                                          reset,
  input  logic                                          polarity,
  input  router_pkg::port_vec_t                         in_ready,
  input  router_pkg::port_vec_t                         out_valid,
  input  router_pkg::port_vec_t                         out_ready,
  input  router_pkg::flit_t [router_pkg::NUM_PORTS-1:0] out_flit,
  output int                                            received,
  output int                                            value_errors,
  output int                                            protocol_errors
);
  import router_pkg::*;
  `include "router_tb_table.svh"

  int                    seen [2][NUM_ROWS];
  // Last tag seen per source and exit port
  int                    last_tag [NUM_PORTS][NUM_PORTS];
  int                    rx_count;
  int                    value_count;
  int                    protocol_count;
  logic                  prev_pol;
  logic                  after_reset;
  port_vec_t             held;
  flit_t [NUM_PORTS-1:0] prev_flit;

  initial begin
    rx_count       = 0;
    value_count    = 0;
    protocol_count = 0;
    held           = '0;
    for (int a = 0; a < 2; a++) begin
      for (int b = 0; b < NUM_ROWS; b++) begin
        seen[a][b] = 0;
      end
    end
    for (int s = 0; s < NUM_PORTS; s++) begin
      for (int d = 0; d < NUM_PORTS; d++) begin
        last_tag[s][d] = -1;
      end
    end
  end

  task automatic report_value(string msg);
    value_count++;
    $display("Fail at %0t: %s", $time, msg);
  endtask

  // Match one departing flit against its table row by tag
  task automatic check_exit(int port, flit_t flit);
    int         tag;
    int         row;
    int         pass;
    table_row_t r;
    flit_t      expected;
    tag  = int'(flit[15:0]);
    row  = tag % TAG_STRIDE;
    pass = tag / TAG_STRIDE;
    rx_count++;
    if (row >= NUM_ROWS || pass > 1) begin
      report_value($sformatf("port %0d sent unknown tag %0d", port, tag));
    end else begin
      r        = table_row(row);
      expected = build_flit(r, tag, 1'b1);
      if (port != int'(r.dst)) begin
        report_value($sformatf("tag %0d left on port %0d, expected %0d", tag, port, r.dst));
      end
      if (flit != expected) begin
        report_value($sformatf("tag %0d flit %h, expected %h", tag, flit, expected));
      end
      seen[pass][row]++;
      if (seen[pass][row] > 1) begin
        protocol_count++;
        $display("Duplicate flit at %0t: tag %0d left the router again", $time, tag);
      end
      // Same source to same exit keeps send order
      if (tag <= last_tag[r.src][port]) begin
        report_value($sformatf("tag %0d on port %0d overtook tag %0d", last_tag[r.src][port],
                               port, tag));
      end
      last_tag[r.src][port] = tag;
    end
  endtask

  // ----------------------------------------------------------------------
  // Sampling on the rising edge, before the DUT updates
  // ----------------------------------------------------------------------
  always @(posedge clk) begin
    if (reset) begin
      if (out_valid != '0) report_value("out_valid high during reset");
      if (in_ready != '1) report_value("in_ready low during reset");
      if (polarity != 1'b0) report_value("polarity not 0 during reset");
      after_reset = 1'b1;
      held        = '0;
    end else begin
      // Polarity starts at 0 and flips on every edge after that
      if (after_reset) begin
        if (polarity != 1'b0) report_value("polarity not 0 after reset");
      end else if (polarity == prev_pol) begin
        report_value("polarity did not toggle");
      end
      after_reset = 1'b0;
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (held[p]) begin
          if (!out_valid[p]) begin
            protocol_count++;
            $display("Handshake broken at %0t: port %0d dropped out_valid while stalled",
                     $time, p);
          end else if (out_flit[p] != prev_flit[p]) begin
            report_value($sformatf("port %0d flit changed while stalled", p));
          end
        end else if (out_valid[p] && out_flit[p][VC_BIT] != prev_pol) begin
          // New flit was pushed in the slot of the previous polarity
          report_value($sformatf("port %0d flit VC %0b outside its slot", p,
                                 out_flit[p][VC_BIT]));
        end
        if (out_valid[p] && out_ready[p]) check_exit(p, out_flit[p]);
      end
      held      = out_valid & ~out_ready;
      prev_flit = out_flit;
    end
    prev_pol = polarity;
    received        <= rx_count;
    value_errors    <= value_count;
    protocol_errors <= protocol_count;
  end

endmodule

/* dv/router_tb.sv */
// ----------------------------------------------------------------------
// Router testbench: table-driven flits on all five links, a clean pass
// and then a pass with random back-pressure on the outputs
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module router_tb;
  import router_pkg::*;
  `include "router_tb_table.svh"

  // Two passes over the table, 40 cycles per flit plus settling
  localparam int MAX_CYCLES = 2 * NUM_ROWS * 40 + 200;

  logic                  clk;
  logic                  reset;
  port_vec_t             in_valid;
  flit_t [NUM_PORTS-1:0] in_flit;
  port_vec_t             in_ready;
  port_vec_t             out_valid;
  flit_t [NUM_PORTS-1:0] out_flit;
  port_vec_t             out_ready;
  logic                  polarity;
  int                    received;
  int                    value_errors;
  int                    protocol_errors;
  int                    cycles;
  int                    pass;
  int                    row_ptr [NUM_PORTS];
  logic [23:0]           lfsr;

  // Index order 0 up, 1 down, 2 left, 3 right, 4 nic
  mesh_router mesh_router_inst (
    .clk(clk),
    .reset(reset),
    .up_in_valid(in_valid[0]), .up_in_flit(in_flit[0]), .up_in_ready(in_ready[0]),
    .up_out_valid(out_valid[0]), .up_out_flit(out_flit[0]), .up_out_ready(out_ready[0]),
    .down_in_valid(in_valid[1]), .down_in_flit(in_flit[1]), .down_in_ready(in_ready[1]),
    .down_out_valid(out_valid[1]), .down_out_flit(out_flit[1]), .down_out_ready(out_ready[1]),
    .left_in_valid(in_valid[2]), .left_in_flit(in_flit[2]), .left_in_ready(in_ready[2]),
    .left_out_valid(out_valid[2]), .left_out_flit(out_flit[2]), .left_out_ready(out_ready[2]),
    .right_in_valid(in_valid[3]), .right_in_flit(in_flit[3]), .right_in_ready(in_ready[3]),
    .right_out_valid(out_valid[3]), .right_out_flit(out_flit[3]), .right_out_ready(out_ready[3]),
    .nic_in_valid(in_valid[4]), .nic_in_flit(in_flit[4]), .nic_in_ready(in_ready[4]),
    .nic_out_valid(out_valid[4]), .nic_out_flit(out_flit[4]), .nic_out_ready(out_ready[4]),
    .polarity_to_nic(polarity)
  );

  router_checker checker_inst (
    .clk             (clk),
    .reset           (reset),
    .polarity        (polarity),
    .in_ready        (in_ready),
    .out_valid       (out_valid),
    .out_ready       (out_ready),
    .out_flit        (out_flit),
    .received        (received),
    .value_errors    (value_errors),
    .protocol_errors (protocol_errors)
  );

  always #2 clk = ~clk;

  // 24-bit Fibonacci LFSR, taps 24 23 22 17
  function automatic logic [23:0] lfsr_next(logic [23:0] s);
    return {s[22:0], s[23] ^ s[22] ^ s[21] ^ s[16]};
  endfunction

  // ----------------------------------------------------------------------
  // Stimulus, each link walks the table rows that start on it
  // ----------------------------------------------------------------------
  always @(posedge clk) begin
    int         r;
    logic       found;
    table_row_t row;
    if (!reset) begin
      // Second pass once every flit of the first has left
      if (pass == 0 && received >= NUM_ROWS) begin
        pass = 1;
        for (int p = 0; p < NUM_PORTS; p++) row_ptr[p] = 0;
      end
      for (int p = 0; p < NUM_PORTS; p++) begin
        // Hold valid and flit until the handshake
        if (!in_valid[p] || in_ready[p]) begin
          found = 1'b0;
          r     = row_ptr[p];
          while (!found && r < NUM_ROWS) begin
            row = table_row(r);
            if (int'(row.src) == p) found = 1'b1;
            else r++;
          end
          if (found) begin
            in_valid[p] <= 1'b1;
            in_flit[p]  <= build_flit(row, pass * TAG_STRIDE + r, 1'b0);
            row_ptr[p]  = r + 1;
          end else begin
            in_valid[p] <= 1'b0;
          end
        end
        // Back-pressure only in the second pass
        if (pass == 0) begin
          out_ready[p] <= 1'b1;
        end else begin
          lfsr = lfsr_next(lfsr);
          out_ready[p] <= lfsr[0];
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, only %0d of %0d flits left the router",
               cycles, received, 2 * NUM_ROWS);
      $display("Something failed");
      $finish;
    end
  end

  initial begin
    clk       = 1'b0;
    reset     = 1'b1;
    in_valid  = '0;
    in_flit   = '0;
    out_ready = '1;
    cycles    = 0;
    pass      = 0;
    lfsr      = 24'd70234;
    for (int p = 0; p < NUM_PORTS; p++) row_ptr[p] = 0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    wait (received >= 2 * NUM_ROWS);
    // Room for a late duplicate to show up
    repeat (20) @(posedge clk);
    $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* project.f */
+incdir+dv
verilog/router_pkg.sv
verilog/flit_buffer.sv
verilog/input_port.sv
verilog/rr_arbiter.sv
verilog/output_port.sv
verilog/mesh_router.sv
dv/router_checker.sv
dv/router_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the mesh router testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary -Wno-fatal --top-module router_tb \
  -f project.f --Mdir obj_dir -o router_sim

./obj_dir/router_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Something failed" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi

if ! grep -q "Everything OK" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi

echo "Simulation passed"
